/* filelist.f */
vga_timing_pkg.sv
vga_pixel_pkg.sv
vga_timing_gen.sv
vga_config_regs.sv
vga_pattern_gen.sv
vga_display_top.sv
tb_vga_display.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the VGA display testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

TOP=tb_vga_display
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module "$TOP" \
    -f filelist.f \
    -o "$TOP"

./obj_dir/"$TOP" > "$LOG" 2>&1
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "Testbench reported a failure, see $LOG"
    exit 1
fi

echo "Testbench run finished, see $LOG"

/* tb_vga_display.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vga_display;

    import vga_pixel_pkg::*;

    localparam int H_ACT        = 32;
    localparam int H_FP         = 4;
    localparam int H_SW         = 6;
    localparam int H_BP         = 6;
    localparam int V_ACT        = 12;
    localparam int V_FP         = 2;
    localparam int V_SW         = 2;
    localparam int V_BP         = 3;
    localparam int BAR_SH       = 2;
    localparam int CHK_SH       = 1;
    localparam int H_TOT        = H_ACT + H_FP + H_SW + H_BP;
    localparam int V_TOT        = V_ACT + V_FP + V_SW + V_BP;
    localparam int FRAME_CYCLES = H_TOT * V_TOT;
    localparam int NUM_WRITES   = 16;

    logic      pclk;
    logic      reset;
    logic      cfg_valid;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_data;
    logic      cfg_ready;
    rgb_t      rgb;
    logic      de;
    logic      hsync;
    logic      vsync;

    logic [31:0]   lcg_state   = 32'h77712c96;
    int            cyc         = 0;
    int            error_count = 0;
    int            pixel_count = 0;
    int            frame_count = 0;
    logic          timed_out   = 1'b0;

    // Reference raster tracker, sampled on the falling clock edge
    logic          h_lock      = 1'b0;
    logic          v_lock      = 1'b0;
    int            x           = 0;
    int            y           = 0;
    logic          hs_prev     = 1'b1;
    logic          vs_prev     = 1'b1;
    logic          s_reset     = 1'b1;
    logic          s_hs        = 1'b1;
    logic          s_vs        = 1'b1;
    logic          s_de        = 1'b0;
    rgb_t          s_rgb       = 12'h000;
    logic          fire        = 1'b0;
    logic          fire_prev   = 1'b0;
    logic          applied     = 1'b0;
    logic [3:0]    rdy_hist    = 4'hF;    // Bit 0 is the newest sample
    logic          exp_de      = 1'b0;
    logic          exp_hs      = 1'b1;
    logic          exp_vs      = 1'b1;
    rgb_t          exp_rgb     = 12'h000;

    // Live configuration model and writes waiting for a frame boundary
    logic          model_en    = 1'b0;
    pattern_mode_t model_mode  = PAT_BARS;
    rgb_t          model_fg    = 12'hFFF;
    rgb_t          model_bg    = 12'h000;
    cfg_addr_t     q_addr[$];
    cfg_data_t     q_data[$];
    int            q_edge[$];

    vga_display_top #(
        .H_ACTIVE      (H_ACT),
        .H_FRONT       (H_FP),
        .H_SYNC        (H_SW),
        .H_BACK        (H_BP),
        .V_ACTIVE      (V_ACT),
        .V_FRONT       (V_FP),
        .V_SYNC        (V_SW),
        .V_BACK        (V_BP),
        .BAR_SHIFT     (BAR_SH),
        .CHECKER_SHIFT (CHK_SH)
    ) dut_i (
        .pclk        (pclk),
        .reset       (reset),
        .cfg_valid_i (cfg_valid),
        .cfg_addr_i  (cfg_addr),
        .cfg_data_i  (cfg_data),
        .cfg_ready_o (cfg_ready),
        .rgb_o       (rgb),
        .de_o        (de),
        .hsync_o     (hsync),
        .vsync_o     (vsync)
    );

    initial pclk = 1'b0;
    always #10 pclk = ~pclk;

    always @(posedge pclk) cyc <= cyc + 1;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic rgb_t expected_rgb(input int px, input int py, input pattern_mode_t mode,
                                          input rgb_t fg, input rgb_t bg);
        logic [2:0] bar;
        rgb_t       color;
        bar = 3'((px >> BAR_SH) % 8);
        case (mode)
            PAT_SOLID:   color = fg;
            PAT_BARS:    color = BAR_COLORS[bar];
            PAT_CHECKER: color = (((px >> CHK_SH) ^ (py >> CHK_SH)) % 2 == 1) ? bg : fg;
            default:     color = {4'(px % 16), 4'(py % 16), bg[3:0]};    // Gradient
        endcase
        return color;
    endfunction

    function automatic void apply_write(input cfg_addr_t a, input cfg_data_t d);
        case (a)
            ADDR_CTRL: begin
                model_en   = d[0];
                model_mode = pattern_mode_t'(d[2:1]);
            end
            ADDR_FG: model_fg = d;
            ADDR_BG: model_bg = d;
            default: ;    // Address 3 has no register
        endcase
    endfunction

    always @(negedge pclk) begin
        s_reset   = reset;
        s_hs      = hsync;
        s_vs      = vsync;
        s_de      = de;
        s_rgb     = rgb;
        fire_prev = fire;
        fire      = cfg_valid && cfg_ready;
        rdy_hist  = {rdy_hist[2:0], cfg_ready};
        applied   = 1'b0;
        if (h_lock) begin
            x = (x == H_TOT - 1) ? 0 : x + 1;
            if (v_lock && x == 0) begin
                y = (y == V_TOT - 1) ? 0 : y + 1;
            end
        end
        if (!h_lock && !reset && hs_prev && !hsync) begin
            h_lock = 1'b1;
            x      = H_ACT + H_FP;    // First sync pixel of the line
        end
        if (h_lock && !v_lock && vs_prev && !vsync) begin
            v_lock = 1'b1;
            y      = V_ACT + V_FP;
        end
        hs_prev = hsync;
        vs_prev = vsync;
        // Pixel (0,0) leaves the pipeline two cycles after the counters wrap
        if (v_lock && x == 0 && y == 0) begin
            frame_count++;
            if (q_edge.size() > 0 && q_edge[0] <= cyc - 3) begin
                apply_write(q_addr[0], q_data[0]);
                void'(q_addr.pop_front());
                void'(q_data.pop_front());
                void'(q_edge.pop_front());
                applied = 1'b1;
            end
        end
        if (fire) begin
            q_addr.push_back(cfg_addr);
            q_data.push_back(cfg_data);
            q_edge.push_back(cyc + 1);    // Edge that takes the write
        end
        exp_de  = (x < H_ACT) && (y < V_ACT);
        exp_hs  = !(x >= H_ACT + H_FP && x < H_ACT + H_FP + H_SW);    // Active low
        exp_vs  = !(y >= V_ACT + V_FP && y < V_ACT + V_FP + V_SW);
        exp_rgb = (exp_de && model_en) ? expected_rgb(x, y, model_mode, model_fg, model_bg)
                                       : 12'h000;
        if (v_lock && exp_de) begin
            pixel_count++;
        end
    end

    reset_state: assert property (@(posedge pclk)
        (s_reset && cyc >= 2) |-> (s_hs && s_vs && !s_de && s_rgb == 12'h000 && rdy_hist[0]))
    else begin
        error_count++;
        $display("[ERROR] reset state hsync_o=%h vsync_o=%h de_o=%h rgb_o=%h cfg_ready_o=%h",
                 s_hs, s_vs, s_de, s_rgb, rdy_hist[0]);
    end

    hsync_timing: assert property (@(posedge pclk) h_lock |-> (s_hs == exp_hs))
    else begin
        error_count++;
        $display("[ERROR] hsync_o got %h expected %h at x=%0d y=%0d", s_hs, exp_hs, x, y);
    end

    vsync_timing: assert property (@(posedge pclk) v_lock |-> (s_vs == exp_vs))
    else begin
        error_count++;
        $display("[ERROR] vsync_o got %h expected %h at x=%0d y=%0d", s_vs, exp_vs, x, y);
    end

    de_window: assert property (@(posedge pclk) v_lock |-> (s_de == exp_de))
    else begin
        error_count++;
        $display("[ERROR] de_o got %h expected %h at x=%0d y=%0d", s_de, exp_de, x, y);
    end

    blank_black: assert property (@(posedge pclk) !s_de |-> (s_rgb == 12'h000))
    else begin
        error_count++;
        $display("[ERROR] rgb_o got %h expected 000 while de_o is low", s_rgb);
    end

    pixel_color: assert property (@(posedge pclk) v_lock |-> (s_rgb == exp_rgb))
    else begin
        error_count++;
        $display("[ERROR] rgb_o got %h expected %h at x=%0d y=%0d mode %0d",
                 s_rgb, exp_rgb, x, y, model_mode);
    end

    stall_until_frame_end: assert property (@(posedge pclk)
        (v_lock && !rdy_hist[3] && rdy_hist[2]) |-> (x == 0 && y == 0))
    else begin
        error_count++;
        $display("cfg_ready_o came back high before the frame ended (x=%0d y=%0d)", x, y);
    end

    stall_after_write: assert property (@(posedge pclk)
        (rdy_hist[1] && !rdy_hist[0]) |-> fire_prev)
    else begin
        error_count++;
        $display("cfg_ready_o dropped although no write was accepted");
    end

    ready_after_update: assert property (@(posedge pclk)
        applied |-> (rdy_hist[2] && !rdy_hist[3]))
    else begin
        error_count++;
        $display("cfg_ready_o did not return high right after the frame that applied a write");
    end

    task automatic send_write(input cfg_addr_t addr, input cfg_data_t data);
        int waited;
        waited = 0;
        @(posedge pclk);
        #1;
        cfg_valid = 1'b1;
        cfg_addr  = addr;
        cfg_data  = data;
        @(negedge pclk);
        while (!cfg_ready && waited < 3 * FRAME_CYCLES) begin
            @(negedge pclk);
            waited++;
        end
        if (!cfg_ready) begin
            $display("Timeout: a write to address %0d was never accepted", addr);
            timed_out = 1'b1;
        end
        @(posedge pclk);    // Transfer edge
        #1;
        cfg_valid = 1'b0;
    endtask

    task automatic wait_frames(input int n);
        int start;
        int waited;
        start  = frame_count;
        waited = 0;
        while (frame_count < start + n && waited < (n + 2) * FRAME_CYCLES) begin
            @(negedge pclk);
            waited++;
        end
        if (frame_count < start + n) begin
            $display("Timeout: the raster did not reach %0d more frame starts", n);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        logic [31:0] r;
        cfg_addr_t   addr;
        cfg_data_t   data;
        logic [1:0]  mode;
        logic        en;
        int          gap;
        cfg_valid = 1'b0;
        cfg_addr  = '0;
        cfg_data  = '0;
        reset     = 1'b1;
        repeat (5) @(posedge pclk);
        #1;
        reset = 1'b0;
        wait_frames(1);
        for (int i = 0; i < NUM_WRITES && !timed_out; i++) begin
            r = next_random();
            if (i % 2 == 0) begin
                mode = 2'(i / 2);    // Steps through all four modes
                en   = (i < 8) || (r[2:0] != 3'd0);    // First pass shows every mode
                addr = ADDR_CTRL;
                data = {9'd0, mode, en};
            end else begin
                addr = (r[9:8] == 2'd0) ? ADDR_FG : r[9:8];
                data = r[27:16];
            end
            send_write(addr, data);
            r   = next_random();
            gap = int'(r[20:16]) + (r[31] ? 300 : 0);    // Short gaps stall behind the pending write
            repeat (gap) @(posedge pclk);
        end
        if (!timed_out) begin
            wait_frames(3);
        end
        writes_drained: assert (q_edge.size() == 0)
        else begin
            error_count++;
            $display("A configuration write was accepted but never applied");
        end
        $display("Errors: %0d, timeout: %0d, pixels checked: %0d, frames: %0d",
                 error_count, timed_out, pixel_count, frame_count);
        if (error_count == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vga_config_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_config_regs (
    input  wire                          pclk,
    input  wire                          reset,
    input  wire                          cfg_valid_i,
    input  wire vga_pixel_pkg::cfg_addr_t cfg_addr_i,
    input  wire vga_pixel_pkg::cfg_data_t cfg_data_i,
    input  wire                          frame_end_i,
    output logic                         cfg_ready_o,
    output logic                         enable_o,
    output vga_pixel_pkg::pattern_mode_t mode_o,
    output vga_pixel_pkg::rgb_t          fg_color_o,
    output vga_pixel_pkg::rgb_t          bg_color_o
);

    import vga_pixel_pkg::*;

    cfg_addr_t     shadow_addr;
    cfg_data_t     shadow_data;
    logic          pending;
    logic          write_fire;
    logic          apply;

    logic          enable_q;
    pattern_mode_t mode_q;
    rgb_t          fg_q;
    rgb_t          bg_q;

    assign cfg_ready_o = !pending;    // One slot, stalls until the frame ends
    assign write_fire  = cfg_valid_i && cfg_ready_o;
    assign apply       = pending && frame_end_i;

    always_ff @(posedge pclk) begin
        if (write_fire) begin
            shadow_addr <= cfg_addr_i;
            shadow_data <= cfg_data_i;
        end
    end

    always_ff @(posedge pclk) begin
        if (reset) begin
            pending  <= 1'b0;
            enable_q <= 1'b0;
            mode_q   <= PAT_BARS;
            fg_q     <= 12'hFFF;
            bg_q     <= 12'h000;
        end else if (apply) begin
            pending <= 1'b0;
            case (shadow_addr)
                ADDR_CTRL: begin
                    enable_q <= shadow_data[0];
                    mode_q   <= pattern_mode_t'(shadow_data[2:1]);
                end
                ADDR_FG:   fg_q <= rgb_t'(shadow_data);
                ADDR_BG:   bg_q <= rgb_t'(shadow_data);
                default:   ;    // Unmapped address, word is dropped
            endcase
        end else if (write_fire) begin
            pending <= 1'b1;
        end
    end

    assign enable_o   = enable_q;
    assign mode_o     = mode_q;
    assign fg_color_o = fg_q;
    assign bg_color_o = bg_q;

endmodule

`default_nettype wire

/* vga_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_display_top #(
    parameter int H_ACTIVE      = vga_timing_pkg::H_ACTIVE,
    parameter int H_FRONT       = vga_timing_pkg::H_FRONT,
    parameter int H_SYNC        = vga_timing_pkg::H_SYNC,
    parameter int H_BACK        = vga_timing_pkg::H_BACK,
    parameter int V_ACTIVE      = vga_timing_pkg::V_ACTIVE,
    parameter int V_FRONT       = vga_timing_pkg::V_FRONT,
    parameter int V_SYNC        = vga_timing_pkg::V_SYNC,
    parameter int V_BACK        = vga_timing_pkg::V_BACK,
    parameter int BAR_SHIFT     = 6,
    parameter int CHECKER_SHIFT = 5
) (
    input  wire                          pclk,
    input  wire                          reset,
    input  wire                          cfg_valid_i,
    input  wire vga_pixel_pkg::cfg_addr_t cfg_addr_i,
    input  wire vga_pixel_pkg::cfg_data_t cfg_data_i,
    output logic                         cfg_ready_o,
    output vga_pixel_pkg::rgb_t          rgb_o,
    output logic                         de_o,
    output logic                         hsync_o,
    output logic                         vsync_o
);

    import vga_timing_pkg::*;
    import vga_pixel_pkg::*;

    coord_t        h_pos;
    coord_t        v_pos;
    logic          raw_de;
    logic          raw_hsync;
    logic          raw_vsync;
    logic          frame_end;
    logic          enable;
    pattern_mode_t mode;
    rgb_t          fg_color;
    rgb_t          bg_color;

    vga_timing_gen #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) timing_i (
        .pclk        (pclk),
        .reset       (reset),
        .h_pos_o     (h_pos),
        .v_pos_o     (v_pos),
        .de_o        (raw_de),
        .hsync_o     (raw_hsync),
        .vsync_o     (raw_vsync),
        .frame_end_o (frame_end)
    );

    vga_config_regs config_i (
        .pclk        (pclk),
        .reset       (reset),
        .cfg_valid_i (cfg_valid_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_data_i  (cfg_data_i),
        .frame_end_i (frame_end),
        .cfg_ready_o (cfg_ready_o),
        .enable_o    (enable),
        .mode_o      (mode),
        .fg_color_o  (fg_color),
        .bg_color_o  (bg_color)
    );

    vga_pattern_gen #(
        .BAR_SHIFT     (BAR_SHIFT),
        .CHECKER_SHIFT (CHECKER_SHIFT)
    ) pattern_i (
        .pclk       (pclk),
        .reset      (reset),
        .h_pos_i    (h_pos),
        .v_pos_i    (v_pos),
        .de_i       (raw_de),
        .hsync_i    (raw_hsync),
        .vsync_i    (raw_vsync),
        .enable_i   (enable),
        .mode_i     (mode),
        .fg_color_i (fg_color),
        .bg_color_i (bg_color),
        .rgb_o      (rgb_o),
        .de_o       (de_o),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o)
    );

endmodule

`default_nettype wire

/* vga_pattern_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_pattern_gen #(
    parameter int BAR_SHIFT     = 6,
    parameter int CHECKER_SHIFT = 5
) (
    input  wire                              pclk,
    input  wire                              reset,
    input  wire vga_timing_pkg::coord_t      h_pos_i,
    input  wire vga_timing_pkg::coord_t      v_pos_i,
    input  wire                              de_i,
    input  wire                              hsync_i,
    input  wire                              vsync_i,
    input  wire                              enable_i,
    input  wire vga_pixel_pkg::pattern_mode_t mode_i,
    input  wire vga_pixel_pkg::rgb_t         fg_color_i,
    input  wire vga_pixel_pkg::rgb_t         bg_color_i,
    output vga_pixel_pkg::rgb_t              rgb_o,
    output logic                             de_o,
    output logic                             hsync_o,
    output logic                             vsync_o
);

    import vga_timing_pkg::*;
    import vga_pixel_pkg::*;

    coord_t        bar_x;
    coord_t        chk_x;
    coord_t        chk_y;

    // Stage 1
    logic [2:0]    s1_bar_idx;
    logic          s1_checker;
    channel_t      s1_grad_r;
    channel_t      s1_grad_g;
    pattern_mode_t s1_mode;
    rgb_t          s1_fg;
    rgb_t          s1_bg;
    logic          s1_enable;
    logic          s1_de;
    logic          s1_hsync;
    logic          s1_vsync;

    // Stage 2
    rgb_t          pixel_color;
    rgb_t          rgb_q;
    logic          de_q;
    logic          hsync_q;
    logic          vsync_q;

    assign bar_x = h_pos_i >> BAR_SHIFT;
    assign chk_x = h_pos_i >> CHECKER_SHIFT;
    assign chk_y = v_pos_i >> CHECKER_SHIFT;

    // Config travels with the pixel so a frame-end update cannot hit the previous pixel
    always_ff @(posedge pclk) begin
        s1_bar_idx <= bar_x[2:0];
        s1_checker <= chk_x[0] ^ chk_y[0];
        s1_grad_r  <= channel_t'(h_pos_i[3:0]);
        s1_grad_g  <= channel_t'(v_pos_i[3:0]);
        s1_mode    <= mode_i;
        s1_fg      <= fg_color_i;
        s1_bg      <= bg_color_i;
    end

    always_ff @(posedge pclk) begin
        if (reset) begin
            s1_enable <= 1'b0;
            s1_de     <= 1'b0;
            s1_hsync  <= 1'b1;
            s1_vsync  <= 1'b1;
        end else begin
            s1_enable <= enable_i;
            s1_de     <= de_i;
            s1_hsync  <= hsync_i;
            s1_vsync  <= vsync_i;
        end
    end

    always_comb begin
        pixel_color = s1_fg;
        case (s1_mode)
            PAT_SOLID:    pixel_color = s1_fg;
            PAT_BARS:     pixel_color = BAR_COLORS[s1_bar_idx];
            PAT_CHECKER:  pixel_color = s1_checker ? s1_bg : s1_fg;
            PAT_GRADIENT: pixel_color = {s1_grad_r, s1_grad_g, s1_bg[3:0]};    // Blue from bg
            default:      pixel_color = s1_fg;
        endcase
    end

    always_ff @(posedge pclk) begin
        if (reset) begin
            rgb_q   <= '0;
            de_q    <= 1'b0;
            hsync_q <= 1'b1;
            vsync_q <= 1'b1;
        end else begin
            rgb_q   <= (s1_de && s1_enable) ? pixel_color : '0;    // Black in blanking
            de_q    <= s1_de;
            hsync_q <= s1_hsync;
            vsync_q <= s1_vsync;
        end
    end

    assign rgb_o   = rgb_q;
    assign de_o    = de_q;
    assign hsync_o = hsync_q;
    assign vsync_o = vsync_q;

endmodule

`default_nettype wire

/* vga_pixel_pkg.sv */
`default_nettype none

package vga_pixel_pkg;

    typedef logic [3:0]  channel_t;
    typedef logic [11:0] rgb_t;       // Red in [11:8], blue in [3:0]
    typedef logic [1:0]  cfg_addr_t;
    typedef logic [11:0] cfg_data_t;

    typedef enum logic [1:0] {
        PAT_SOLID    = 2'd0,
        PAT_BARS     = 2'd1,
        PAT_CHECKER  = 2'd2,
        PAT_GRADIENT = 2'd3
    } pattern_mode_t;

    // Register map, address 3 is accepted and ignored
    localparam cfg_addr_t ADDR_CTRL = 2'd0;    // Bit 0 enable, bits 2:1 mode
    localparam cfg_addr_t ADDR_FG   = 2'd1;
    localparam cfg_addr_t ADDR_BG   = 2'd2;

    // Classic color bars, left to right
    localparam rgb_t BAR_COLORS [8] = '{
        12'hFFF,    // White
        12'hFF0,    // Yellow
        12'h0FF,    // Cyan
        12'h0F0,    // Green
        12'hF0F,    // Magenta
        12'hF00,    // Red
        12'h00F,    // Blue
        12'h000     // Black
    };

endpackage

`default_nettype wire

/* vga_timing_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing_gen #(
    parameter int H_ACTIVE = vga_timing_pkg::H_ACTIVE,
    parameter int H_FRONT  = vga_timing_pkg::H_FRONT,
    parameter int H_SYNC   = vga_timing_pkg::H_SYNC,
    parameter int H_BACK   = vga_timing_pkg::H_BACK,
    parameter int V_ACTIVE = vga_timing_pkg::V_ACTIVE,
    parameter int V_FRONT  = vga_timing_pkg::V_FRONT,
    parameter int V_SYNC   = vga_timing_pkg::V_SYNC,
    parameter int V_BACK   = vga_timing_pkg::V_BACK
) (
    input  wire                    pclk,
    input  wire                    reset,
    output vga_timing_pkg::coord_t h_pos_o,
    output vga_timing_pkg::coord_t v_pos_o,
    output logic                   de_o,
    output logic                   hsync_o,
    output logic                   vsync_o,
    output logic                   frame_end_o
);

    import vga_timing_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam coord_t H_LAST     = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST     = coord_t'(V_TOTAL - 1);
    localparam coord_t H_DE_END   = coord_t'(H_ACTIVE);
    localparam coord_t V_DE_END   = coord_t'(V_ACTIVE);
    localparam coord_t HS_START   = coord_t'(H_ACTIVE + H_FRONT);
    localparam coord_t HS_END     = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam coord_t VS_START   = coord_t'(V_ACTIVE + V_FRONT);
    localparam coord_t VS_END     = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

    coord_t h_cnt;
    coord_t v_cnt;
    coord_t h_next;
    coord_t v_next;
    logic   line_end;
    logic   hsync_q;
    logic   vsync_q;

    assign line_end = (h_cnt == H_LAST);

    always_comb begin
        h_next = line_end ? '0 : h_cnt + coord_t'(1);
        v_next = v_cnt;
        if (line_end) begin
            v_next = (v_cnt == V_LAST) ? '0 : v_cnt + coord_t'(1);
        end
    end

    // Syncs are decoded from the next count so they line up with the counters
    always_ff @(posedge pclk) begin
        if (reset) begin
            h_cnt   <= '0;
            v_cnt   <= '0;
            hsync_q <= 1'b1;
            vsync_q <= 1'b1;
        end else begin
            h_cnt   <= h_next;
            v_cnt   <= v_next;
            hsync_q <= !((h_next >= HS_START) && (h_next < HS_END));    // Active low
            vsync_q <= !((v_next >= VS_START) && (v_next < VS_END));
        end
    end

    assign h_pos_o     = h_cnt;
    assign v_pos_o     = v_cnt;
    assign hsync_o     = hsync_q;
    assign vsync_o     = vsync_q;
    assign de_o        = (h_cnt < H_DE_END) && (v_cnt < V_DE_END);
    assign frame_end_o = line_end && (v_cnt == V_LAST);    // Last pixel of the frame

endmodule

`default_nettype wire

/* vga_timing_pkg.sv */
`default_nettype none

package vga_timing_pkg;

    // Horizontal or vertical raster position
    typedef logic [9:0] coord_t;

    // Horizontal timing in pixels, 640x480 at 60 Hz
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;

    // Vertical timing in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;

endpackage

`default_nettype wire
